/* build.f */
+incdir+bench
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/sys_gpu_decoder.sv
rtl/base_decoder.sv
rtl/warp_ctrl.sv
rtl/decode_stage.sv
bench/decode_asserts.sv
bench/tb_decode.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log
verilator --binary --timing --assert --top-module tb_decode -f build.f -o sim_decode \
    && { ./obj_dir/sim_decode > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Test failed" sim.log \
    && grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* bench/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// Expected decode of one fetch record, plus the join and stall flags
function automatic void model_decode(input fetch_t f, output decode_t d,
                                     output logic join_op, output logic stall_op);
    logic [31:0] ins;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        f7b5;
    logic        use_rd;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    reg_num_t    rd;
    reg_num_t    rs1;
    reg_num_t    rs2;
    ins      = f.instr;
    opc      = ins[6:0];
    f3       = ins[14:12];
    f7b5     = ins[30];
    rd       = ins[11:7];
    rs1      = ins[19:15];
    rs2      = ins[24:20];
    i_imm    = {{20{ins[31]}}, ins[31:20]};
    s_imm    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    b_imm    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    j_imm    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    d        = '0;
    use_rd   = 1'b0;
    join_op  = 1'b0;
    stall_op = 1'b0;
    case (opc)
        OPC_I, OPC_R: begin
            d.ex_type = EX_ALU;
            use_rd    = 1'b1;
            d.rd      = rd;
            d.rs1     = rs1;
            case (f3)
                3'd0: d.op_type = (opc == OPC_R && f7b5) ? ALU_SUB : ALU_ADD;
                3'd1: d.op_type = ALU_SLL;
                3'd2: d.op_type = ALU_SLT;
                3'd3: d.op_type = ALU_SLTU;
                3'd4: d.op_type = ALU_XOR;
                3'd5: d.op_type = f7b5 ? ALU_SRA : ALU_SRL;
                3'd6: d.op_type = ALU_OR;
                default: d.op_type = ALU_AND;
            endcase
            if (opc == OPC_R) begin
                d.rs2 = rs2;
            end else begin
                d.use_imm = 1'b1;
                // Shift amount, zero extended
                d.imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, ins[24:20]} : i_imm;
            end
        end
        OPC_LUI, OPC_AUIPC: begin
            d.ex_type = EX_ALU;
            d.op_type = (opc == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
            use_rd    = 1'b1;
            d.rd      = rd;
            d.use_imm = 1'b1;
            d.use_pc  = (opc == OPC_AUIPC);
            d.imm     = {ins[31:12], 12'h000};
        end
        OPC_JAL, OPC_JALR: begin
            d.ex_type = EX_ALU;
            d.op_mod  = MOD_BRANCH;
            use_rd    = 1'b1;
            d.rd      = rd;
            d.use_imm = 1'b1;
            stall_op  = 1'b1;
            if (opc == OPC_JAL) begin
                d.op_type = BR_JAL;
                d.use_pc  = 1'b1;
                d.imm     = j_imm;
            end else begin
                d.op_type = BR_JALR;
                d.rs1     = rs1;
                d.imm     = i_imm;
            end
        end
        OPC_B: begin
            d.ex_type = EX_ALU;
            d.op_mod  = MOD_BRANCH;
            // Branch codes equal func3, reserved 2 and 3 read as zero
            d.op_type = (f3[2:1] == 2'b01) ? 4'd0 : {1'b0, f3};
            d.rs1     = rs1;
            d.rs2     = rs2;
            d.imm     = b_imm;
            d.use_imm = 1'b1;
            d.use_pc  = 1'b1;
            stall_op  = 1'b1;
        end
        OPC_L: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b0, f3};
            use_rd    = 1'b1;
            d.rd      = rd;
            d.rs1     = rs1;
            d.imm     = i_imm;
        end
        OPC_S: begin
            d.ex_type = EX_LSU;
            d.op_type = {1'b1, f3};
            d.rs1     = rs1;
            d.rs2     = rs2;
            d.imm     = s_imm;
        end
        OPC_FENCE: begin
            d.ex_type = EX_LSU;
            d.op_type = {3'b000, f3[0]};
            d.op_mod  = 3'd1;
        end
        OPC_SYS: begin
            use_rd = 1'b1;
            d.rd   = rd;
            if (f3[1:0] != 2'b00) begin
                d.ex_type = EX_CSR;
                d.op_type = {2'b00, f3[1:0]};
                d.use_imm = f3[2];
                d.imm     = f3[2] ? {15'b0, rs1, ins[31:20]} : {20'b0, ins[31:20]};
                d.rs1     = f3[2] ? 5'd0 : rs1;
            end else begin
                d.ex_type = EX_ALU;
                d.op_mod  = MOD_BRANCH;
                d.use_imm = 1'b1;
                d.use_pc  = 1'b1;
                d.imm     = 32'd4;
                stall_op  = 1'b1;
                case (ins[31:20])
                    12'h000: d.op_type = BR_ECALL;
                    12'h001: d.op_type = BR_EBREAK;
                    12'h302: d.op_type = BR_MRET;
                    12'h102: d.op_type = BR_SRET;
                    12'h7b2: d.op_type = BR_DRET;
                    default: d.op_type = 4'd0;
                endcase
            end
        end
        OPC_GPU: begin
            d.ex_type = EX_GPU;
            case (f3)
                3'd0: begin
                    d.op_type = rs2[0] ? GPU_PRED : GPU_TMC;
                    d.rs1     = rs1;
                    stall_op  = 1'b1;
                end
                3'd1: begin
                    d.op_type = GPU_WSPAWN;
                    d.rs1     = rs1;
                    d.rs2     = rs2;
                end
                3'd2: begin
                    d.op_type = GPU_SPLIT;
                    d.rs1     = rs1;
                    stall_op  = 1'b1;
                end
                3'd3: begin
                    d.op_type = GPU_JOIN;
                    join_op   = 1'b1;
                end
                3'd4: begin
                    d.op_type = GPU_BAR;
                    d.rs1     = rs1;
                    d.rs2     = rs2;
                    stall_op  = 1'b1;
                end
                3'd5: begin
                    d.ex_type = EX_LSU;
                    d.op_type = LSU_LW;
                    d.rs1     = rs1;
                    d.use_imm = 1'b1;
                    d.imm     = {{27{rs1[4]}}, rs1};
                end
                default: d.op_type = 4'd0;
            endcase
        end
        default: d.ex_type = EX_NOP;
    endcase
    d.wid   = f.wid;
    d.tmask = f.tmask;
    d.pc    = f.pc;
    d.wb    = use_rd && (d.rd != 5'd0);
endfunction

`endif

/* bench/tb_decode.sv */
`default_nettype none

module tb_decode;
    import decode_pkg::*;

    `include "decode_model.svh"

    localparam int          NUM_TESTS    = 3000;
    localparam int          RESET_CYCLES = 8;
    localparam int          MAX_CYCLES   = NUM_TESTS + 100;
    localparam logic [31:0] SEED         = 32'h644a_c03f;

    logic    clk;
    logic    rst_n;
    logic    fetch_valid;
    fetch_t  fetch;
    logic    fetch_ready;
    logic    dec_valid;
    decode_t dec;
    logic    dec_ready;
    logic    join_valid;
    wid_t    join_wid;
    logic    wstall_valid;
    wid_t    wstall_wid;
    logic    wstall_stalled;

    logic [31:0] lfsr;
    int          cycles;
    int          n;
    logic [6:0]  kept_ops [12];
    logic [11:0] ret_codes [5];

    decode_stage DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .fetch_ready    (fetch_ready),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .dec_ready      (dec_ready),
        .join_valid     (join_valid),
        .join_wid       (join_wid),
        .wstall_valid   (wstall_valid),
        .wstall_wid     (wstall_wid),
        .wstall_stalled (wstall_stalled)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic take_bits(input int count, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic string group_name(input logic [31:0] ins);
        case (ins[6:0])
            OPC_I:     return "alu_imm";
            OPC_R:     return "alu_reg";
            OPC_LUI:   return "lui";
            OPC_AUIPC: return "auipc";
            OPC_JAL:   return "jal";
            OPC_JALR:  return "jalr";
            OPC_B:     return "branch";
            OPC_L:     return "load";
            OPC_S:     return "store";
            OPC_FENCE: return "fence";
            OPC_SYS:   return (ins[13:12] != 2'b00) ? "csr" : "system";
            OPC_GPU:   return "gpu";
            default:   return "unknown";
        endcase
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] ins;
        logic [6:0]  opc;
        logic [3:0]  idx;
        logic [2:0]  sel;
        // Hold the fetch record while it is stalled
        if (!(fetch_valid && !dec_ready)) begin
            take_bits(5, r);
            if (r < 28) begin
                idx = 4'(r % 12);
                opc = kept_ops[idx];
            end else begin
                take_bits(7, r);
                opc = r[6:0];
            end
            take_bits(25, r);
            ins = {r[24:0], opc};
            if (opc == OPC_SYS) begin
                take_bits(3, r);
                if (r < 5) begin   // Force a trap or return code
                    sel        = r[2:0];
                    ins[31:20] = ret_codes[sel];
                    ins[13:12] = 2'b00;
                end
            end
            fetch.instr = ins;
            take_bits(2, r);
            fetch.wid = r[1:0];
            take_bits(4, r);
            fetch.tmask = r[3:0];
            take_bits(32, r);
            fetch.pc = r;
            take_bits(2, r);
            fetch_valid = (r[1:0] != 2'b00);
        end
        take_bits(2, r);
        dec_ready = (r[1:0] != 2'b00);
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s.%s expected %0h actual %0h", test, field, expected, actual);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs();
        decode_t exp;
        logic    exp_join;
        logic    exp_stall;
        logic    fire;
        string   tag;
        model_decode(fetch, exp, exp_join, exp_stall);
        tag  = group_name(fetch.instr);
        fire = fetch_valid && dec_ready;
        check_value(tag, "fetch_ready", 32'(dec_ready), 32'(fetch_ready));
        check_value(tag, "dec_valid", 32'(fetch_valid), 32'(dec_valid));
        check_value(tag, "wid", 32'(exp.wid), 32'(dec.wid));
        check_value(tag, "tmask", 32'(exp.tmask), 32'(dec.tmask));
        check_value(tag, "pc", exp.pc, dec.pc);
        check_value(tag, "ex_type", 32'(exp.ex_type), 32'(dec.ex_type));
        check_value(tag, "op_type", 32'(exp.op_type), 32'(dec.op_type));
        check_value(tag, "op_mod", 32'(exp.op_mod), 32'(dec.op_mod));
        check_value(tag, "wb", 32'(exp.wb), 32'(dec.wb));
        check_value(tag, "rd", 32'(exp.rd), 32'(dec.rd));
        check_value(tag, "rs1", 32'(exp.rs1), 32'(dec.rs1));
        check_value(tag, "rs2", 32'(exp.rs2), 32'(dec.rs2));
        check_value(tag, "rs3", 32'(exp.rs3), 32'(dec.rs3));
        check_value(tag, "imm", exp.imm, dec.imm);
        check_value(tag, "use_pc", 32'(exp.use_pc), 32'(dec.use_pc));
        check_value(tag, "use_imm", 32'(exp.use_imm), 32'(dec.use_imm));
        check_value(tag, "wstall_valid", 32'(fire), 32'(wstall_valid));
        check_value(tag, "join_valid", 32'(fire && exp_join), 32'(join_valid));
        if (fire) begin
            check_value(tag, "wstall_wid", 32'(fetch.wid), 32'(wstall_wid));
            check_value(tag, "wstall_stalled", 32'(exp_stall), 32'(wstall_stalled));
        end
        if (fire && exp_join) begin
            check_value(tag, "join_wid", 32'(fetch.wid), 32'(join_wid));
        end
    endtask

    initial begin
        kept_ops = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_B, OPC_L,
                     OPC_S, OPC_I, OPC_R, OPC_FENCE, OPC_SYS, OPC_GPU};
        ret_codes = '{12'h000, 12'h001, 12'h302, 12'h102, 12'h7b2};
        lfsr        = SEED;
        cycles      = 0;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch       = '0;
        dec_ready   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (n = 0; n < NUM_TESTS; n++) begin
            @(negedge clk);
            drive_random();
            @(posedge clk);   // Inputs settled since the falling edge
            check_outputs();
        end
        @(negedge clk);
        fetch_valid = 1'b0;
        dec_ready   = 1'b0;
        $display("Test completed successfully");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test loop did not finish", cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* bench/decode_asserts.sv */
`default_nettype none

module decode_asserts (
    input wire clk,
    input wire rst_n,
    input wire fetch_valid,
    input wire fetch_ready,
    input wire dec_ready,
    input wire join_valid,
    input wire wstall_valid
);

    // Every join also produces a stall report
    join_has_stall: assert property (@(posedge clk) disable iff (!rst_n)
        join_valid |-> wstall_valid)
        else $error("join strobe fired without a stall report");

    ready_passthrough: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ready == dec_ready)
        else $error("fetch_ready does not follow dec_ready");

    stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wstall_valid |-> fetch_valid)
        else $error("stall report fired with no valid fetch");

endmodule

bind decode_stage decode_asserts u_decode_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .dec_ready    (dec_ready),
    .join_valid   (join_valid),
    .wstall_valid (wstall_valid)
);

`default_nettype wire

/* rtl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     fetch_valid,
    input  wire decode_pkg::fetch_t fetch,
    output logic                    fetch_ready,
    output logic                    dec_valid,
    output decode_pkg::decode_t     dec,
    input  wire                     dec_ready,
    output logic                    join_valid,
    output decode_pkg::wid_t        join_wid,
    output logic                    wstall_valid,
    output decode_pkg::wid_t        wstall_wid,
    output logic                    wstall_stalled
);
    import decode_pkg::*;

    // clk and rst_n are only observed by bound checkers
    imm_sel_e imm_sel;
    imm_t     imm;
    logic     is_gpu;
    uop_t     sys_gpu_uop;
    uop_t     uop;

    base_decoder u_base_decoder (
        .instr       (fetch.instr),
        .imm         (imm),
        .sys_gpu_uop (sys_gpu_uop),
        .imm_sel     (imm_sel),
        .is_gpu      (is_gpu),
        .uop         (uop)
    );

    sys_gpu_decoder u_sys_gpu_decoder (
        .instr  (fetch.instr),
        .is_gpu (is_gpu),
        .uop    (sys_gpu_uop)
    );

    imm_gen u_imm_gen (
        .instr   (fetch.instr),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    warp_ctrl u_warp_ctrl (
        .fetch_valid    (fetch_valid),
        .fetch          (fetch),
        .dec_ready      (dec_ready),
        .uop            (uop),
        .fetch_ready    (fetch_ready),
        .dec_valid      (dec_valid),
        .dec            (dec),
        .join_valid     (join_valid),
        .join_wid       (join_wid),
        .wstall_valid   (wstall_valid),
        .wstall_wid     (wstall_wid),
        .wstall_stalled (wstall_stalled)
    );

endmodule

`default_nettype wire

/* rtl/warp_ctrl.sv */
`default_nettype none

module warp_ctrl (
    input  wire                     fetch_valid,
    input  wire decode_pkg::fetch_t fetch,
    input  wire                     dec_ready,
    input  wire decode_pkg::uop_t   uop,
    output logic                    fetch_ready,
    output logic                    dec_valid,
    output decode_pkg::decode_t     dec,
    output logic                    join_valid,
    output decode_pkg::wid_t        join_wid,
    output logic                    wstall_valid,
    output decode_pkg::wid_t        wstall_wid,
    output logic                    wstall_stalled
);
    import decode_pkg::*;

    logic fire;

    assign fetch_ready = dec_ready;
    assign dec_valid   = fetch_valid;
    assign fire        = fetch_valid && dec_ready;

    always_comb begin
        dec.wid     = fetch.wid;
        dec.tmask   = fetch.tmask;
        dec.pc      = fetch.pc;
        dec.ex_type = uop.ex_type;
        dec.op_type = uop.op_type;
        dec.op_mod  = uop.op_mod;
        dec.wb      = uop.use_rd && (uop.rd != '0);   // r0 is never written
        dec.rd      = uop.rd;
        dec.rs1     = uop.rs1;
        dec.rs2     = uop.rs2;
        dec.rs3     = uop.rs3;
        dec.imm     = uop.imm;
        dec.use_pc  = uop.use_pc;
        dec.use_imm = uop.use_imm;
    end

    assign join_valid     = fire && uop.is_join;
    assign join_wid       = fetch.wid;
    assign wstall_valid   = fire;   // Reported for every accepted instruction
    assign wstall_wid     = fetch.wid;
    assign wstall_stalled = uop.is_wstall;

endmodule

`default_nettype wire

/* rtl/base_decoder.sv */
`default_nettype none

module base_decoder (
    input  wire decode_pkg::instr_t instr,
    input  wire decode_pkg::imm_t   imm,
    input  wire decode_pkg::uop_t   sys_gpu_uop,
    output decode_pkg::imm_sel_e    imm_sel,
    output logic                    is_gpu,
    output decode_pkg::uop_t        uop
);
    import decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    reg_num_t   rd;
    reg_num_t   rs1;
    reg_num_t   rs2;
    op_type_t   alu_op;
    op_type_t   br_op;

    assign opcode = opcode_e'(instr[6:0]);
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign is_gpu = (opcode == OPC_GPU);

    // ALU function shared by the I and R forms
    always_comb begin
        case (func3)
            3'h0: alu_op = ALU_ADD;
            3'h1: alu_op = ALU_SLL;
            3'h2: alu_op = ALU_SLT;
            3'h3: alu_op = ALU_SLTU;
            3'h4: alu_op = ALU_XOR;
            3'h5: alu_op = func7[5] ? ALU_SRA : ALU_SRL;
            3'h6: alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (func3)
            3'h1: br_op = BR_NE;
            3'h4: br_op = BR_LT;
            3'h5: br_op = BR_GE;
            3'h6: br_op = BR_LTU;
            3'h7: br_op = BR_GEU;
            default: br_op = BR_EQ;   // Also covers the reserved 2 and 3
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_I:            imm_sel = (func3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
            OPC_JALR, OPC_L:  imm_sel = IMM_I;
            OPC_S:            imm_sel = IMM_S;
            OPC_B:            imm_sel = IMM_B;
            OPC_LUI, OPC_AUIPC: imm_sel = IMM_U;
            OPC_JAL:          imm_sel = IMM_J;
            default:          imm_sel = IMM_NONE;
        endcase
    end

    always_comb begin
        uop = '0;
        case (opcode)
            OPC_I: begin
                uop.ex_type = EX_ALU;
                uop.op_type = alu_op;
                uop.use_rd  = 1'b1;
                uop.use_imm = 1'b1;
                uop.imm     = imm;
                uop.rd      = rd;
                uop.rs1     = rs1;
            end
            OPC_R: begin
                uop.ex_type = EX_ALU;
                uop.op_type = (func3 == 3'h0 && func7[5]) ? ALU_SUB : alu_op;
                uop.use_rd  = 1'b1;
                uop.rd      = rd;
                uop.rs1     = rs1;
                uop.rs2     = rs2;
            end
            OPC_LUI, OPC_AUIPC: begin
                uop.ex_type = EX_ALU;
                uop.op_type = (opcode == OPC_LUI) ? ALU_LUI : ALU_AUIPC;
                uop.use_rd  = 1'b1;
                uop.use_imm = 1'b1;
                uop.use_pc  = (opcode == OPC_AUIPC);
                uop.imm     = imm;
                uop.rd      = rd;
            end
            OPC_JAL, OPC_JALR: begin
                uop.ex_type   = EX_ALU;
                uop.op_type   = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
                uop.op_mod    = MOD_BRANCH;
                uop.use_rd    = 1'b1;
                uop.use_imm   = 1'b1;
                uop.use_pc    = (opcode == OPC_JAL);   // JALR adds to rs1
                uop.is_wstall = 1'b1;
                uop.imm       = imm;
                uop.rd        = rd;
                uop.rs1       = (opcode == OPC_JALR) ? rs1 : '0;
            end
            OPC_B: begin
                uop.ex_type   = EX_ALU;
                uop.op_type   = br_op;
                uop.op_mod    = MOD_BRANCH;
                uop.use_imm   = 1'b1;
                uop.use_pc    = 1'b1;
                uop.is_wstall = 1'b1;
                uop.imm       = imm;
                uop.rs1       = rs1;
                uop.rs2       = rs2;
            end
            OPC_L: begin
                uop.ex_type = EX_LSU;
                uop.op_type = op_type_t'({1'b0, func3});
                uop.use_rd  = 1'b1;
                uop.imm     = imm;
                uop.rd      = rd;
                uop.rs1     = rs1;
            end
            OPC_S: begin
                uop.ex_type = EX_LSU;
                uop.op_type = op_type_t'({1'b1, func3});
                uop.imm     = imm;
                uop.rs1     = rs1;
                uop.rs2     = rs2;
            end
            OPC_FENCE: begin
                uop.ex_type = EX_LSU;
                uop.op_type = op_type_t'(func3[0]);
                uop.op_mod  = op_mod_t'(1);
            end
            OPC_SYS, OPC_GPU: uop = sys_gpu_uop;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/sys_gpu_decoder.sv */
`default_nettype none

module sys_gpu_decoder (
    input  wire decode_pkg::instr_t instr,
    input  wire                     is_gpu,
    output decode_pkg::uop_t        uop
);
    import decode_pkg::*;

    logic [2:0]  func3;
    logic [11:0] u_12;
    reg_num_t    rd;
    reg_num_t    rs1;
    reg_num_t    rs2;

    assign func3 = instr[14:12];
    assign u_12  = instr[31:20];
    assign rd    = instr[11:7];
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];

    always_comb begin
        uop = '0;
        if (is_gpu) begin
            uop.ex_type = EX_GPU;
            case (func3)
                3'h0: begin
                    uop.op_type   = rs2[0] ? GPU_PRED : GPU_TMC;
                    uop.is_wstall = 1'b1;
                    uop.rs1       = rs1;
                end
                3'h1: begin
                    uop.op_type = GPU_WSPAWN;
                    uop.rs1     = rs1;
                    uop.rs2     = rs2;
                end
                3'h2: begin
                    uop.op_type   = GPU_SPLIT;
                    uop.is_wstall = 1'b1;
                    uop.rs1       = rs1;
                end
                3'h3: begin
                    uop.op_type = GPU_JOIN;
                    uop.is_join = 1'b1;
                end
                3'h4: begin
                    uop.op_type   = GPU_BAR;
                    uop.is_wstall = 1'b1;
                    uop.rs1       = rs1;
                    uop.rs2       = rs2;
                end
                3'h5: begin
                    // Issued to the LSU as a word load
                    uop.ex_type = EX_LSU;
                    uop.op_type = LSU_LW;
                    uop.use_imm = 1'b1;
                    uop.imm     = {{(XLEN-REG_BITS){rs1[REG_BITS-1]}}, rs1};
                    uop.rs1     = rs1;
                end
                default: ;
            endcase
        end else if (func3[1:0] != 2'b00) begin
            uop.ex_type = EX_CSR;
            uop.op_type = op_type_t'(func3[1:0]);   // RW, RS, RC
            uop.use_rd  = 1'b1;
            uop.use_imm = func3[2];
            uop.rd      = rd;
            uop.imm[CSR_ADDR_BITS-1:0] = u_12;
            if (func3[2]) begin
                uop.imm[CSR_ADDR_BITS +: CSR_IMM_BITS] = rs1;
            end else begin
                uop.rs1 = rs1;
            end
        end else begin
            uop.ex_type = EX_ALU;
            case (u_12)
                12'h000: uop.op_type = BR_ECALL;
                12'h001: uop.op_type = BR_EBREAK;
                12'h302: uop.op_type = BR_MRET;
                12'h102: uop.op_type = BR_SRET;
                12'h7b2: uop.op_type = BR_DRET;
                default: ;
            endcase
            uop.op_mod    = MOD_BRANCH;
            uop.use_rd    = 1'b1;
            uop.use_imm   = 1'b1;
            uop.use_pc    = 1'b1;
            uop.is_wstall = 1'b1;
            uop.imm       = 32'd4;   // Link address offset
            uop.rd        = rd;
        end
    end

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`default_nettype none

module imm_gen (
    input  wire decode_pkg::instr_t   instr,
    input  wire decode_pkg::imm_sel_e imm_sel,
    output decode_pkg::imm_t          imm
);
    import decode_pkg::*;

    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [12:0] b_imm;
    logic [19:0] u_imm;
    logic [20:0] j_imm;
    reg_num_t    shamt;

    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = instr[31:12];
    assign j_imm = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = instr[24:20];   // Sits in the rs2 field

    always_comb begin
        case (imm_sel)
            IMM_I:     imm = {{20{i_imm[11]}}, i_imm};
            IMM_SHAMT: imm = {{(XLEN-REG_BITS){1'b0}}, shamt};
            IMM_S:     imm = {{20{s_imm[11]}}, s_imm};
            IMM_B:     imm = {{19{b_imm[12]}}, b_imm};
            IMM_U:     imm = {u_imm, 12'b0};
            IMM_J:     imm = {{11{j_imm[20]}}, j_imm};
            default:   imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int XLEN        = 32;
    localparam int REG_BITS    = 5;
    localparam int OP_BITS     = 4;
    localparam int MOD_BITS    = 3;
    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;
    localparam int WID_BITS    = $clog2(NUM_WARPS);

    localparam int CSR_ADDR_BITS = 12;
    localparam int CSR_IMM_BITS  = 5;

    typedef logic [XLEN-1:0]        instr_t;
    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [XLEN-1:0]        imm_t;
    typedef logic [REG_BITS-1:0]    reg_num_t;
    typedef logic [WID_BITS-1:0]    wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [OP_BITS-1:0]     op_type_t;
    typedef logic [MOD_BITS-1:0]    op_mod_t;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_JAL   = 7'b1101111,
        OPC_JALR  = 7'b1100111,
        OPC_B     = 7'b1100011,
        OPC_L     = 7'b0000011,
        OPC_S     = 7'b0100011,
        OPC_I     = 7'b0010011,
        OPC_R     = 7'b0110011,
        OPC_FENCE = 7'b0001111,
        OPC_SYS   = 7'b1110011,
        OPC_GPU   = 7'b1101011  // Custom warp control space
    } opcode_e;

    typedef enum logic [2:0] {
        EX_NOP = 3'd0,
        EX_ALU = 3'd1,
        EX_LSU = 3'd2,
        EX_CSR = 3'd3,
        EX_GPU = 3'd4
    } ex_type_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHAMT,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_CSR
    } imm_sel_e;

    localparam op_type_t ALU_ADD   = 4'd0;
    localparam op_type_t ALU_SUB   = 4'd1;
    localparam op_type_t ALU_SLL   = 4'd2;
    localparam op_type_t ALU_SLT   = 4'd3;
    localparam op_type_t ALU_SLTU  = 4'd4;
    localparam op_type_t ALU_XOR   = 4'd5;
    localparam op_type_t ALU_SRL   = 4'd6;
    localparam op_type_t ALU_SRA   = 4'd7;
    localparam op_type_t ALU_OR    = 4'd8;
    localparam op_type_t ALU_AND   = 4'd9;
    localparam op_type_t ALU_LUI   = 4'd10;
    localparam op_type_t ALU_AUIPC = 4'd11;

    // Branch unit ops, issued to the ALU with MOD_BRANCH
    localparam op_type_t BR_EQ     = 4'd0;
    localparam op_type_t BR_NE     = 4'd1;
    localparam op_type_t BR_LT     = 4'd4;
    localparam op_type_t BR_GE     = 4'd5;
    localparam op_type_t BR_LTU    = 4'd6;
    localparam op_type_t BR_GEU    = 4'd7;
    localparam op_type_t BR_JAL    = 4'd8;
    localparam op_type_t BR_JALR   = 4'd9;
    localparam op_type_t BR_ECALL  = 4'd10;
    localparam op_type_t BR_EBREAK = 4'd11;
    localparam op_type_t BR_MRET   = 4'd12;
    localparam op_type_t BR_SRET   = 4'd13;
    localparam op_type_t BR_DRET   = 4'd14;

    localparam op_type_t GPU_TMC    = 4'd0;
    localparam op_type_t GPU_WSPAWN = 4'd1;
    localparam op_type_t GPU_SPLIT  = 4'd2;
    localparam op_type_t GPU_JOIN   = 4'd3;
    localparam op_type_t GPU_BAR    = 4'd4;
    localparam op_type_t GPU_PRED   = 4'd5;

    localparam op_type_t LSU_LW = 4'd2;

    localparam op_mod_t MOD_BRANCH = 3'd1;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        addr_t  pc;
        instr_t instr;
    } fetch_t;

    typedef struct packed {
        ex_type_e ex_type;
        op_type_t op_type;
        op_mod_t  op_mod;
        logic     use_rd;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        reg_num_t rs3;
        imm_t     imm;
        logic     use_pc;
        logic     use_imm;
        logic     is_join;
        logic     is_wstall;    // Warp waits for this op to resolve
    } uop_t;

    typedef struct packed {
        wid_t     wid;
        tmask_t   tmask;
        addr_t    pc;
        ex_type_e ex_type;
        op_type_t op_type;
        op_mod_t  op_mod;
        logic     wb;
        reg_num_t rd;
        reg_num_t rs1;
        reg_num_t rs2;
        reg_num_t rs3;
        imm_t     imm;
        logic     use_pc;
        logic     use_imm;
    } decode_t;

endpackage

`default_nettype wire
